/* Makefile */
SIM       = verilator
FLAGS     = --binary --timing --assert -j 0
TOP       = tb_mem_subsystem
FILELIST  = files.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Test OK

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list these targets"
	@echo "  test   build with $(SIM), run $(TOP) and search $(LOG) for the pass line"
	@echo "  clean  remove $(BUILD_DIR) and $(LOG)"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)
	-./$(BUILD_DIR)/V$(TOP) > $(LOG) 2>&1
	@cat $(LOG)
	@if grep -qx "$(PASS_MSG)" $(LOG); then \
		echo "Simulation passed"; \
	else \
		echo "Simulation did not pass, see $(LOG)"; \
		exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* data_ram.sv */
`timescale 1ns/100ps

module data_ram import mem_stage_pkg::*; (
    input  logic     CLK,
    input  logic     nRST,
    input  logic     dbus_valid,
    input  logic     dbus_wen,
    input  word_t    dbus_addr,
    input  byte_en_t dbus_byte_en,
    input  word_t    dbus_wdata,
    output logic     dbus_ready,
    output word_t    dbus_rdata,
    output logic     dbus_error
);

    word_t              mem [DMEM_WORDS];
    logic               wait_q;
    logic               in_range;
    logic               complete;
    logic [DMEM_AW-1:0] word_idx;

    assign word_idx = dbus_addr[DMEM_AW+1:2];

    // Anything above the array is unmapped
    assign in_range = (dbus_addr[31:DMEM_AW+2] == '0);

    // One wait state per request
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            wait_q <= 1'b0;
        end else begin
            wait_q <= dbus_valid & ~wait_q;
        end
    end

    assign dbus_ready = wait_q;
    assign complete   = dbus_valid & wait_q;

    // Unmapped reads return zero
    assign dbus_rdata = in_range ? mem[word_idx] : '0;
    assign dbus_error = complete & ~in_range;

    // Byte-lane writes on the completing cycle
    always_ff @(posedge CLK) begin
        if (complete && dbus_wen && in_range) begin
            for (int i = 0; i < 4; i++) begin
                if (dbus_byte_en[i]) begin
                    mem[word_idx][i*8 +: 8] <= dbus_wdata[i*8 +: 8];
                end
            end
        end
    end

endmodule

/* fence_tracker.sv */
`timescale 1ns/100ps

module fence_tracker (
    input  logic CLK,
    input  logic nRST,
    input  logic fence_i,
    input  logic iflush_done,
    input  logic dflush_done,
    output logic icache_flush,
    output logic dcache_flush,
    output logic fence_stall
);

    logic fence_reg;
    logic fence_pulse;
    logic iflushed;
    logic dflushed;
    logic iflushed_next;
    logic dflushed_next;

    // First cycle of a new FENCE.I
    assign fence_pulse = fence_i & ~fence_reg;

    // Both caches are flushed together
    assign icache_flush = fence_pulse;
    assign dcache_flush = fence_pulse;

    // Hold until both caches have answered
    assign fence_stall = fence_pulse | (fence_reg & ~(iflushed & dflushed));

    always_comb begin
        iflushed_next = iflushed;
        dflushed_next = dflushed;
        if (fence_pulse) begin
            iflushed_next = 1'b0;
            dflushed_next = 1'b0;
        end
        // Done pulses win over a new request
        if (iflush_done) begin
            iflushed_next = 1'b1;
        end
        if (dflush_done) begin
            dflushed_next = 1'b1;
        end
    end

    // Edge register drops on completion, so back-to-back fences pulse again
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            fence_reg <= 1'b0;
            iflushed  <= 1'b1;
            dflushed  <= 1'b1;
        end else begin
            fence_reg <= fence_i & fence_stall;
            iflushed  <= iflushed_next;
            dflushed  <= dflushed_next;
        end
    end

endmodule

/* files.f */
mem_stage_pkg.sv
store_formatter.sv
load_extender.sv
fence_tracker.sv
mem_stage.sv
data_ram.sv
mem_subsystem.sv
mem_subsystem_assertions.sv
tb_mem_subsystem.sv

/* load_extender.sv */
`timescale 1ns/100ps

module load_extender import mem_stage_pkg::*; (
    input  word_t      rdata,
    input  mem_width_e width,
    input  logic [1:0] addr_low,
    output word_t      ext_data
);

    word_t shifted;
    logic  byte_sign;
    logic  half_sign;

    // Bring the addressed lane down to bit 0
    assign shifted = rdata >> {addr_low, 3'b000};

    assign byte_sign = shifted[7];
    assign half_sign = shifted[15];

    always_comb begin
        case (width)
            MW_B: begin
                ext_data = {{24{byte_sign}}, shifted[7:0]};
            end
            MW_BU: begin
                ext_data = {24'h00_0000, shifted[7:0]};
            end
            MW_H: begin
                ext_data = {{16{half_sign}}, shifted[15:0]};
            end
            MW_HU: begin
                ext_data = {16'h0000, shifted[15:0]};
            end
            MW_W: begin
                ext_data = rdata;
            end
            default: begin
                // Raw word when the access is not a load
                ext_data = rdata;
            end
        endcase
    end

endmodule

/* mem_stage.sv */
`timescale 1ns/100ps

module mem_stage import mem_stage_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    // Execute/memory pipeline register
    input  logic       em_valid,
    output logic       em_ready,
    input  word_t      em_pc4,
    input  word_t      em_imm_u,
    input  word_t      em_alu_out,
    input  word_t      em_rs2_data,
    input  reg_idx_t   em_rd,
    input  logic       em_reg_write,
    input  logic       em_dren,
    input  logic       em_dwen,
    input  mem_width_e em_width,
    input  w_sel_e     em_w_sel,
    input  logic       em_fence_i,
    input  logic       em_halt,
    // Data bus
    output logic       dbus_valid,
    output logic       dbus_wen,
    output word_t      dbus_addr,
    output byte_en_t   dbus_byte_en,
    output word_t      dbus_wdata,
    input  logic       dbus_ready,
    input  word_t      dbus_rdata,
    input  logic       dbus_error,
    // Cache control
    output logic       icache_flush,
    output logic       dcache_flush,
    input  logic       iflush_done,
    input  logic       dflush_done,
    // Results
    output logic       wb_valid,
    output reg_idx_t   wb_rd,
    output word_t      wb_data,
    output logic       exc_valid,
    output exc_cause_t exc_cause,
    output word_t      exc_badaddr,
    output logic       halt
);

    logic  mem_op;
    logic  misaligned;
    logic  bus_done;
    logic  fence_stall;
    logic  retire;
    logic  exc_any;
    word_t dload_ext;

    store_formatter u_store_formatter (
        .width      (em_width),
        .addr_low   (em_alu_out[1:0]),
        .rs2_data   (em_rs2_data),
        .byte_en    (dbus_byte_en),
        .wdata      (dbus_wdata),
        .misaligned (misaligned)
    );

    load_extender u_load_extender (
        .rdata    (dbus_rdata),
        .width    (em_width),
        .addr_low (em_alu_out[1:0]),
        .ext_data (dload_ext)
    );

    fence_tracker u_fence_tracker (
        .CLK          (CLK),
        .nRST         (nRST),
        .fence_i      (em_valid & em_fence_i),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .fence_stall  (fence_stall)
    );

    assign mem_op = em_valid & (em_dren | em_dwen);

    // Misaligned accesses never reach the bus
    assign dbus_valid = mem_op & ~misaligned;
    assign dbus_wen   = em_dwen;
    assign dbus_addr  = em_alu_out;
    assign bus_done   = dbus_valid & dbus_ready;

    // Stall on an outstanding bus transfer or an unfinished fence
    assign em_ready = ~(dbus_valid & ~dbus_ready) & ~fence_stall;
    assign retire   = em_valid & em_ready;

    // Misalignment takes priority over a bus error
    always_comb begin
        exc_any   = 1'b1;
        exc_cause = '0;
        if (em_dren & misaligned) begin
            exc_cause = EXC_LOAD_MISALIGNED;
        end else if (em_dwen & misaligned) begin
            exc_cause = EXC_STORE_MISALIGNED;
        end else if (em_dren & bus_done & dbus_error) begin
            exc_cause = EXC_LOAD_FAULT;
        end else if (em_dwen & bus_done & dbus_error) begin
            exc_cause = EXC_STORE_FAULT;
        end else begin
            exc_any = 1'b0;
        end
    end

    assign exc_valid   = retire & mem_op & exc_any;
    assign exc_badaddr = em_alu_out;

    // Faulting instructions do not write the register file
    assign wb_valid = retire & em_reg_write & ~(mem_op & exc_any);
    assign wb_rd    = em_rd;

    always_comb begin
        case (em_w_sel)
            W_SEL_DLOAD: wb_data = dload_ext;
            W_SEL_PC4:   wb_data = em_pc4;
            W_SEL_IMM_U: wb_data = em_imm_u;
            W_SEL_ALU:   wb_data = em_alu_out;
            default:     wb_data = em_alu_out;
        endcase
    end

    assign halt = em_halt;

endmodule

/* mem_stage_pkg.sv */
package mem_stage_pkg;

    // Datapath word for both addresses and data
    typedef logic [31:0] word_t;

    // Architectural register index
    typedef logic [4:0] reg_idx_t;

    // One enable per byte lane of the data bus
    typedef logic [3:0] byte_en_t;

    // RISC-V exception code
    typedef logic [3:0] exc_cause_t;

    // Access width and signedness of a load or store
    typedef enum logic [2:0] {
        MW_B,
        MW_H,
        MW_W,
        MW_BU,
        MW_HU,
        MW_NONE
    } mem_width_e;

    // Writeback source select
    typedef enum logic [1:0] {
        W_SEL_DLOAD,
        W_SEL_PC4,
        W_SEL_IMM_U,
        W_SEL_ALU
    } w_sel_e;

    // Exception codes raised by the memory stage
    localparam exc_cause_t EXC_LOAD_MISALIGNED  = 4'd4;
    localparam exc_cause_t EXC_LOAD_FAULT       = 4'd5;
    localparam exc_cause_t EXC_STORE_MISALIGNED = 4'd6;
    localparam exc_cause_t EXC_STORE_FAULT      = 4'd7;

    // Data memory size in 32-bit words
    localparam int DMEM_WORDS = 256;

    // Word address width into the data memory
    localparam int DMEM_AW = $clog2(DMEM_WORDS);

endpackage

/* mem_subsystem.sv */
`timescale 1ns/100ps

module mem_subsystem import mem_stage_pkg::*; (
    input  logic       CLK,
    input  logic       nRST,
    input  logic       em_valid,
    output logic       em_ready,
    input  word_t      em_pc4,
    input  word_t      em_imm_u,
    input  word_t      em_alu_out,
    input  word_t      em_rs2_data,
    input  reg_idx_t   em_rd,
    input  logic       em_reg_write,
    input  logic       em_dren,
    input  logic       em_dwen,
    input  mem_width_e em_width,
    input  w_sel_e     em_w_sel,
    input  logic       em_fence_i,
    input  logic       em_halt,
    output logic       icache_flush,
    output logic       dcache_flush,
    input  logic       iflush_done,
    input  logic       dflush_done,
    output logic       wb_valid,
    output reg_idx_t   wb_rd,
    output word_t      wb_data,
    output logic       exc_valid,
    output exc_cause_t exc_cause,
    output word_t      exc_badaddr,
    output logic       halt
);

    // Internal data bus
    logic     dbus_valid;
    logic     dbus_wen;
    word_t    dbus_addr;
    byte_en_t dbus_byte_en;
    word_t    dbus_wdata;
    logic     dbus_ready;
    word_t    dbus_rdata;
    logic     dbus_error;

    mem_stage u_mem_stage (
        .CLK          (CLK),
        .nRST         (nRST),
        .em_valid     (em_valid),
        .em_ready     (em_ready),
        .em_pc4       (em_pc4),
        .em_imm_u     (em_imm_u),
        .em_alu_out   (em_alu_out),
        .em_rs2_data  (em_rs2_data),
        .em_rd        (em_rd),
        .em_reg_write (em_reg_write),
        .em_dren      (em_dren),
        .em_dwen      (em_dwen),
        .em_width     (em_width),
        .em_w_sel     (em_w_sel),
        .em_fence_i   (em_fence_i),
        .em_halt      (em_halt),
        .dbus_valid   (dbus_valid),
        .dbus_wen     (dbus_wen),
        .dbus_addr    (dbus_addr),
        .dbus_byte_en (dbus_byte_en),
        .dbus_wdata   (dbus_wdata),
        .dbus_ready   (dbus_ready),
        .dbus_rdata   (dbus_rdata),
        .dbus_error   (dbus_error),
        .icache_flush (icache_flush),
        .dcache_flush (dcache_flush),
        .iflush_done  (iflush_done),
        .dflush_done  (dflush_done),
        .wb_valid     (wb_valid),
        .wb_rd        (wb_rd),
        .wb_data      (wb_data),
        .exc_valid    (exc_valid),
        .exc_cause    (exc_cause),
        .exc_badaddr  (exc_badaddr),
        .halt         (halt)
    );

    data_ram u_data_ram (
        .CLK          (CLK),
        .nRST         (nRST),
        .dbus_valid   (dbus_valid),
        .dbus_wen     (dbus_wen),
        .dbus_addr    (dbus_addr),
        .dbus_byte_en (dbus_byte_en),
        .dbus_wdata   (dbus_wdata),
        .dbus_ready   (dbus_ready),
        .dbus_rdata   (dbus_rdata),
        .dbus_error   (dbus_error)
    );

endmodule

/* mem_subsystem_assertions.sv */
`timescale 1ns/100ps

module mem_subsystem_assertions (
    input logic CLK,
    input logic nRST,
    input logic dbus_valid,
    input logic dbus_ready,
    input logic icache_flush,
    input logic dcache_flush,
    input logic wb_valid,
    input logic exc_valid
);

    // A pending request is held until the memory answers
    a_bus_held: assert property (@(posedge CLK) disable iff (!nRST)
        dbus_valid && !dbus_ready |=> dbus_valid)
        else $error("dbus_valid dropped before dbus_ready");

    // Flush requests are single-cycle pulses
    a_iflush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        icache_flush |=> !icache_flush)
        else $error("icache_flush held for more than one cycle");

    a_dflush_pulse: assert property (@(posedge CLK) disable iff (!nRST)
        dcache_flush |=> !dcache_flush)
        else $error("dcache_flush held for more than one cycle");

    a_wb_exc_exclusive: assert property (@(posedge CLK) disable iff (!nRST)
        !(wb_valid && exc_valid))
        else $error("wb_valid and exc_valid high in the same cycle");

endmodule

bind mem_stage mem_subsystem_assertions u_assertions (
    .CLK          (CLK),
    .nRST         (nRST),
    .dbus_valid   (dbus_valid),
    .dbus_ready   (dbus_ready),
    .icache_flush (icache_flush),
    .dcache_flush (dcache_flush),
    .wb_valid     (wb_valid),
    .exc_valid    (exc_valid)
);

/* store_formatter.sv */
`timescale 1ns/100ps

module store_formatter import mem_stage_pkg::*; (
    input  mem_width_e width,
    input  logic [1:0] addr_low,
    input  word_t      rs2_data,
    output byte_en_t   byte_en,
    output word_t      wdata,
    output logic       misaligned
);

    // Lane selection from access size and byte offset
    always_comb begin
        case (width)
            MW_B, MW_BU: begin
                byte_en = byte_en_t'(4'b0001 << addr_low);
            end
            MW_H, MW_HU: begin
                byte_en = addr_low[1] ? 4'b1100 : 4'b0011;
            end
            MW_W: begin
                byte_en = 4'b1111;
            end
            default: begin
                byte_en = 4'b0000;
            end
        endcase
    end

    // Replicate the store operand so any enabled lane sees it
    always_comb begin
        case (width)
            MW_B, MW_BU: wdata = {4{rs2_data[7:0]}};
            MW_H, MW_HU: wdata = {2{rs2_data[15:0]}};
            default:     wdata = rs2_data;
        endcase
    end

    // Halfwords need even addresses, words need a zero offset
    always_comb begin
        case (width)
            MW_H, MW_HU: misaligned = addr_low[0];
            MW_W:        misaligned = (addr_low != 2'b00);
            default:     misaligned = 1'b0;
        endcase
    end

endmodule

/* tb_mem_subsystem.sv */
`timescale 1ns/100ps

module tb_mem_subsystem import mem_stage_pkg::*; ();

    localparam int          CLK_HALF      = 2;
    localparam int          RESET_CYCLES  = 4;
    localparam int unsigned SEED          = 32'hab1e_7241;
    localparam word_t       REGION_ADDR   = 32'h0000_0100;
    localparam int          REGION_WORDS  = 16;
    localparam int          N_RAND_STORES = 40;
    localparam int          N_RAND_LOADS  = 60;
    localparam int          N_MISALIGNED  = 8;
    localparam int          N_FAULTS      = 8;
    localparam int          N_NON_MEM     = 12;
    localparam int          N_FENCES      = 6;
    localparam int N_INSTR = 2 * REGION_WORDS + N_RAND_STORES + N_RAND_LOADS
                             + N_MISALIGNED + N_FAULTS + N_NON_MEM + N_FENCES;
    localparam int TIMEOUT_CYCLES = RESET_CYCLES + 20 * N_INSTR;

    logic       CLK;
    logic       nRST;
    logic       em_valid;
    logic       em_ready;
    word_t      em_pc4;
    word_t      em_imm_u;
    word_t      em_alu_out;
    word_t      em_rs2_data;
    reg_idx_t   em_rd;
    logic       em_reg_write;
    logic       em_dren;
    logic       em_dwen;
    mem_width_e em_width;
    w_sel_e     em_w_sel;
    logic       em_fence_i;
    logic       em_halt;
    logic       icache_flush;
    logic       dcache_flush;
    logic       iflush_done;
    logic       dflush_done;
    logic       wb_valid;
    reg_idx_t   wb_rd;
    word_t      wb_data;
    logic       exc_valid;
    exc_cause_t exc_cause;
    word_t      exc_badaddr;
    logic       halt;

    // Expected outcome of the instruction on the bus
    logic       exp_wb = 1'b0;
    logic       exp_exc = 1'b0;
    word_t      exp_data = '0;
    exc_cause_t exp_cause = '0;
    int         exp_cycles = 0;

    word_t shadow [DMEM_WORDS];
    int    err_count = 0;
    int    cycle_count = 0;
    int    i_flush_cnt = 0;
    int    d_flush_cnt = 0;
    logic  i_done_seen = 1'b0;
    logic  d_done_seen = 1'b0;

    mem_subsystem u_dut (.*);

    initial begin
        CLK = 1'b0;
        forever #(CLK_HALF) CLK = ~CLK;
    end

    task automatic fail_run();
        $display("Test FAILED");
        $fatal(1, "Simulation stopped at the first failure");
    endtask

    task automatic check(input string what, input word_t got, input word_t exp);
        if (got !== exp) begin
            err_count++;
            $display("ERROR at %0t: %s is 0x%h, expected 0x%h", $time, what, got, exp);
            fail_run();
        end
    endtask

    function automatic word_t region_word(int k);
        return REGION_ADDR + word_t'(4 * k);
    endfunction

    // Random byte offset that keeps an access of this width aligned
    function automatic int aligned_offset(mem_width_e width);
        case (width)
            MW_B, MW_BU: return int'($urandom % 4);
            MW_H, MW_HU: return 2 * int'($urandom % 2);
            default:     return 0;
        endcase
    endfunction

    // Little-endian lane pick with sign or zero fill
    function automatic word_t load_ref(word_t addr, mem_width_e width);
        word_t      w;
        logic [7:0] lo;
        logic [7:0] hi;
        int         off;
        w   = shadow[addr[DMEM_AW+1:2]];
        off = int'(addr[1:0]);
        lo  = w[8*off +: 8];
        hi  = w[8*((off + 1) % 4) +: 8];
        case (width)
            MW_B:    return {{24{lo[7]}}, lo};
            MW_BU:   return {24'h00_0000, lo};
            MW_H:    return {{16{hi[7]}}, hi, lo};
            MW_HU:   return {16'h0000, hi, lo};
            default: return w;
        endcase
    endfunction

    function automatic word_t store_merge(word_t old, word_t data, mem_width_e width, int off);
        word_t w;
        w = old;
        case (width)
            MW_B, MW_BU: w[8*off +: 8] = data[7:0];
            MW_H, MW_HU: w[8*off +: 16] = data[15:0];
            default:     w = data;
        endcase
        return w;
    endfunction

    // Reference model for the instruction currently driven
    function automatic void predict();
        logic is_mem;
        logic misal;
        logic out_of_range;
        int   off;
        off          = int'(em_alu_out[1:0]);
        is_mem       = em_dren || em_dwen;
        misal        = is_mem && (((em_width == MW_H || em_width == MW_HU) && (off % 2 != 0))
                                  || (em_width == MW_W && off != 0));
        out_of_range = is_mem && (em_alu_out >= word_t'(DMEM_WORDS * 4));
        exp_exc      = misal || out_of_range;
        if (misal) begin
            exp_cause = em_dren ? 4'd4 : 4'd6;
        end else begin
            exp_cause = em_dren ? 4'd5 : 4'd7;
        end
        exp_wb = em_reg_write && !exp_exc;
        case (em_w_sel)
            W_SEL_DLOAD: exp_data = load_ref(em_alu_out, em_width);
            W_SEL_PC4:   exp_data = em_pc4;
            W_SEL_IMM_U: exp_data = em_imm_u;
            default:     exp_data = em_alu_out;
        endcase
        // Zero means the latency is not fixed
        if (em_fence_i) begin
            exp_cycles = 0;
        end else if (is_mem && !misal) begin
            exp_cycles = 2;
        end else begin
            exp_cycles = 1;
        end
    endfunction

    task automatic issue(input word_t addr, input word_t rs2, input logic dren,
                         input logic dwen, input mem_width_e width, input w_sel_e sel,
                         input logic reg_write, input logic fence);
        int n;
        int di;
        int dd;
        n  = 0;
        di = 1 + int'($urandom % 8);
        dd = 1 + int'($urandom % 8);
        @(negedge CLK);
        em_valid     = 1'b1;
        em_alu_out   = addr;
        em_rs2_data  = rs2;
        em_pc4       = $urandom;
        em_imm_u     = word_t'($urandom) & 32'hffff_f000;
        em_rd        = reg_idx_t'($urandom);
        em_reg_write = reg_write;
        em_dren      = dren;
        em_dwen      = dwen;
        em_width     = width;
        em_w_sel     = sel;
        em_fence_i   = fence;
        em_halt      = ($urandom % 4) == 0;
        iflush_done  = 1'b0;
        dflush_done  = 1'b0;
        predict();
        @(posedge CLK);
        if (fence) begin
            check("icache_flush", word_t'(icache_flush), 32'd1);
            check("dcache_flush", word_t'(dcache_flush), 32'd1);
        end
        // Wait for retirement, returning done pulses for a fence
        while (!em_ready) begin
            n++;
            @(negedge CLK);
            iflush_done = fence && (n == di);
            dflush_done = fence && (n == dd);
            @(posedge CLK);
        end
        if (exp_cycles != 0) begin
            check("latency", word_t'(n + 1), word_t'(exp_cycles));
        end
        if (dwen && !exp_exc) begin
            shadow[addr[DMEM_AW+1:2]] = store_merge(shadow[addr[DMEM_AW+1:2]], rs2, width,
                                                    int'(addr[1:0]));
        end
    endtask

    task automatic do_load(input word_t addr, input mem_width_e width);
        issue(addr, '0, 1'b1, 1'b0, width, W_SEL_DLOAD, 1'b1, 1'b0);
    endtask

    task automatic do_store(input word_t addr, input word_t data, input mem_width_e width);
        issue(addr, data, 1'b0, 1'b1, width, W_SEL_ALU, 1'b0, 1'b0);
    endtask

    always @(posedge CLK) begin : compare
        if (icache_flush) i_flush_cnt++;
        if (dcache_flush) d_flush_cnt++;
        if (iflush_done) i_done_seen = 1'b1;
        if (dflush_done) d_done_seen = 1'b1;
        check("halt", word_t'(halt), word_t'(em_halt));
        if (em_valid && em_ready) begin
            check("wb_valid", word_t'(wb_valid), word_t'(exp_wb));
            if (exp_wb) begin
                check("wb_rd", word_t'(wb_rd), word_t'(em_rd));
                check("wb_data", wb_data, exp_data);
            end
            check("exc_valid", word_t'(exc_valid), word_t'(exp_exc));
            if (exp_exc) begin
                check("exc_cause", word_t'(exc_cause), word_t'(exp_cause));
                check("exc_badaddr", exc_badaddr, em_alu_out);
            end
            if (em_fence_i) begin
                check("icache flush count", word_t'(i_flush_cnt), 32'd1);
                check("dcache flush count", word_t'(d_flush_cnt), 32'd1);
                check("iflush_done before retire", word_t'(i_done_seen), 32'd1);
                check("dflush_done before retire", word_t'(d_done_seen), 32'd1);
            end
            i_flush_cnt = 0;
            d_flush_cnt = 0;
            i_done_seen = 1'b0;
            d_done_seen = 1'b0;
        end else begin
            check("wb_valid outside retire", word_t'(wb_valid), 32'd0);
            check("exc_valid outside retire", word_t'(exc_valid), 32'd0);
        end
    end

    always @(posedge CLK) begin : watchdog
        cycle_count++;
        if (cycle_count > TIMEOUT_CYCLES) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYCLES);
            fail_run();
        end
    end

    initial begin : stimulus
        int unsigned seed_val;
        mem_width_e  w;
        word_t       a;
        seed_val     = $urandom(SEED);
        nRST         = 1'b0;
        em_valid     = 1'b0;
        em_pc4       = '0;
        em_imm_u     = '0;
        em_alu_out   = '0;
        em_rs2_data  = '0;
        em_rd        = '0;
        em_reg_write = 1'b0;
        em_dren      = 1'b0;
        em_dwen      = 1'b0;
        em_width     = MW_NONE;
        em_w_sel     = W_SEL_ALU;
        em_fence_i   = 1'b0;
        em_halt      = 1'b0;
        iflush_done  = 1'b0;
        dflush_done  = 1'b0;
        repeat (RESET_CYCLES) @(posedge CLK);
        @(negedge CLK);
        nRST = 1'b1;

        // Fill the test region before the mixed stores and loads
        for (int k = 0; k < REGION_WORDS; k++) begin
            do_store(region_word(k), $urandom, MW_W);
        end
        for (int k = 0; k < N_RAND_STORES; k++) begin
            w = mem_width_e'($urandom % 3);
            a = region_word(int'($urandom % REGION_WORDS));
            do_store(a + word_t'(aligned_offset(w)), $urandom, w);
        end
        for (int k = 0; k < N_RAND_LOADS; k++) begin
            w = mem_width_e'($urandom % 5);
            a = region_word(int'($urandom % REGION_WORDS));
            do_load(a + word_t'(aligned_offset(w)), w);
        end

        // Misaligned halfword and word accesses
        for (int k = 0; k < N_MISALIGNED / 4; k++) begin
            a = region_word(int'($urandom % REGION_WORDS));
            do_load(a + 1 + 2 * ($urandom % 2), MW_H);
            do_load(a + 1 + ($urandom % 3), MW_W);
            do_store(a + 1 + 2 * ($urandom % 2), $urandom, MW_H);
            do_store(a + 1 + ($urandom % 3), $urandom, MW_W);
        end

        // Accesses above the array that alias onto the test region
        for (int k = 0; k < N_FAULTS / 2; k++) begin
            w = mem_width_e'($urandom % 3);
            a = word_t'(DMEM_WORDS * 4) * (1 + ($urandom % 64))
                + region_word(int'($urandom % REGION_WORDS));
            do_store(a + word_t'(aligned_offset(w)), $urandom, w);
            do_load(a, MW_W);
        end
        for (int k = 0; k < REGION_WORDS; k++) begin
            do_load(region_word(k), MW_W);
        end

        for (int k = 0; k < N_NON_MEM; k++) begin
            issue($urandom, $urandom, 1'b0, 1'b0, MW_NONE, w_sel_e'(1 + $urandom % 3),
                  ($urandom % 4) != 0, 1'b0);
        end

        for (int k = 0; k < N_FENCES; k++) begin
            issue($urandom, '0, 1'b0, 1'b0, MW_NONE, W_SEL_ALU, 1'b0, 1'b1);
        end

        @(negedge CLK);
        em_valid    = 1'b0;
        iflush_done = 1'b0;
        dflush_done = 1'b0;
        repeat (2) @(posedge CLK);
        if (err_count == 0) begin
            $display("Test OK");
            $finish;
        end else begin
            fail_run();
        end
    end

endmodule
